//--- sources.f
design/kp_lcd_pkg.sv
design/keypad_scanner.sv
design/message_builder.sv
design/lcd1602.sv
design/team_11.sv
testbench/tb_clock.sv
testbench/tb_team_11.sv

//--- testbench/keypad_tests.txt
// key hold pulses line. key is row*4+col on the 123A/456B/789C/*0#D pad, 16 drops en
// hold in clock cycles, pulses of msg_tx_ctrl expected, line is row 2 with _ for space
0 400 1 1_______________
3 400 1 1A______________
13 400 1 1A0_____________
14 400 1 ________________
12 400 0 ________________
5 100 0 ________________
1 400 1 2_______________
2 400 1 23______________
12 400 1 2_______________
4 400 1 24______________
5 400 1 245_____________
6 400 1 2456____________
7 400 1 2456B___________
8 400 1 2456B7__________
9 400 1 2456B78_________
10 400 1 2456B789________
11 400 1 2456B789C_______
15 400 1 2456B789CD______
13 400 1 2456B789CD0_____
0 400 1 2456B789CD01____
1 400 1 2456B789CD012___
2 400 1 2456B789CD0123__
3 400 1 2456B789CD0123A_
7 400 1 2456B789CD0123AB
4 400 0 2456B789CD0123AB
16 50 0 ________________
8 400 1 7_______________
14 400 1 ________________

//--- testbench/tb_team_11.sv
/*
 * Testbench for the keypad LCD terminal
 * Keypad matrix model, LCD bus decoder with a row-2 copy,
 * test file reader, checks, timeout and error count
 */
`timescale 1ns/1ps

module tb_team_11;
    import kp_lcd_pkg::*;

    localparam int ENABLE_TEST = 16;  // Key number that drops en instead
    localparam int PASS_CYCLES = (MSG_LEN + 1) * (LCD_EN_CYCLES + LCD_CMD_WAIT + 2);
    localparam logic [33:0] OEB_PINS = 34'h3_C000_3FFF;  // Rows and spare pins are inputs

    logic                    clk;
    logic                    arst_n;
    logic                    en;
    logic [33:0]             gpio_in;
    logic [33:0]             gpio_out;
    logic [33:0]             gpio_oeb;
    logic                    key_down;    // Keypad model
    logic [1:0]              key_row;
    logic [1:0]              key_col;
    logic [0:MSG_LEN-1][7:0] row2;        // Decoder copy of display row 2
    logic [6:0]              ddram_addr;
    int                      init_cnt;    // Command bytes since init start
    int                      addr_cnt;    // Row-2 address commands seen
    int                      pulse_cnt;   // msg_tx_ctrl pulses
    int                      err_cnt;
    int                      check_cnt;
    int                      cycles;
    int                      cycle_limit;
    int                      t_key[$];
    int                      t_hold[$];
    int                      t_pulses[$];
    logic [8*MSG_LEN-1:0]    t_line[$];

    tb_clock i_tb_clock (.clk(clk), .arst_n(arst_n));

    team_11 i_team_11 (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (en),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oeb (gpio_oeb)
    );

    // Pressed key closes its row onto the driven column
    assign gpio_in[33:30] = (key_down && gpio_out[26 + key_col]) ? 4'b0001 << key_row : 4'b0000;
    assign gpio_in[29:0]  = '0;

    task automatic log_mismatch(input string sig, input logic [127:0] expv,
                                input logic [127:0] actv);
        err_cnt++;
        $display("error at %0t: %s expected %0h actual %0h", $time, sig, expv, actv);
    endtask

    // LCD bus decoder, bytes latch on the fall of lcd_en
    always @(negedge gpio_out[24]) begin
        if (arst_n === 1'b1 && en === 1'b1) begin  // Ignore edges caused by reset
            if (!gpio_out[22] && init_cnt < 4) begin
                check_cnt++;
                if (gpio_out[21:14] !== LCD_INIT_BYTES[init_cnt])
                    log_mismatch("lcd_data init byte", LCD_INIT_BYTES[init_cnt], gpio_out[21:14]);
                init_cnt++;
            end else if (!gpio_out[22]) begin
                if (gpio_out[21]) ddram_addr = gpio_out[20:14];  // Set DDRAM address
                if (gpio_out[21:14] == LCD_ROW2_ADDR) addr_cnt++;
            end else begin
                if (ddram_addr >= 7'h40 && ddram_addr < 7'h40 + MSG_LEN)
                    row2[ddram_addr - 7'h40] = gpio_out[21:14];
                ddram_addr = ddram_addr + 1'b1;  // Entry mode increment
            end
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (gpio_out[25] === 1'b1) pulse_cnt++;
        if (gpio_out[23] !== 1'b0) log_mismatch("lcd_rw", 0, gpio_out[23]);
        if (gpio_oeb !== OEB_PINS) log_mismatch("gpio_oeb", OEB_PINS, gpio_oeb);
        if ({gpio_out[33:30], gpio_out[13:0]} !== 18'h0)
            log_mismatch("unused gpio_out", 0, {gpio_out[33:30], gpio_out[13:0]});
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, run still busy after %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // Columns: key number, hold cycles, expected pulses, expected line with _ as space
    task automatic load_tests(output bit ok);
        int                      fd;
        int                      n;
        int                      key;
        int                      hold;
        int                      pulses;
        string                   text;
        string                   chars;
        logic [0:MSG_LEN-1][7:0] line;
        ok = 1'b0;
        fd = $fopen("testbench/keypad_tests.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (text.len() < 2 || text.substr(0, 1) == "//") continue;  // Blank or comment
            n = $sscanf(text, "%d %d %d %s", key, hold, pulses, chars);
            if (n != 4 || chars.len() != MSG_LEN) begin
                $display("malformed test line: %s", text);
                $fclose(fd);
                return;
            end
            for (int i = 0; i < MSG_LEN; i++)
                line[i] = (chars[i] == "_") ? CHAR_SPACE : chars[i];
            t_key.push_back(key);
            t_hold.push_back(hold);
            t_pulses.push_back(pulses);
            t_line.push_back(line);
        end
        $fclose(fd);
        ok = t_key.size() > 0;
    endtask

    task automatic run_test(input int idx);
        int start_pulses;
        int target;
        start_pulses = pulse_cnt;
        @(negedge clk);
        if (t_key[idx] == ENABLE_TEST) begin
            en = 1'b0;
            repeat (t_hold[idx]) begin
                @(negedge clk);
                check_cnt++;
                if (gpio_out[25:24] !== 2'b00)
                    log_mismatch("msg_tx_ctrl and lcd_en", 0, gpio_out[25:24]);
            end
            init_cnt = 0;  // Init list expected again
            en       = 1'b1;
        end else begin
            key_row  = 2'(t_key[idx] / 4);
            key_col  = 2'(t_key[idx] % 4);
            key_down = 1'b1;
            repeat (t_hold[idx]) @(negedge clk);
            key_down = 1'b0;
            repeat (t_hold[idx]) @(negedge clk);
        end
        target = addr_cnt + 3;  // Two whole passes after the next one starts
        while (addr_cnt < target) @(negedge clk);
        check_cnt += 3;
        if (row2 !== t_line[idx]) log_mismatch("row 2 line", t_line[idx], row2);
        if (pulse_cnt - start_pulses != t_pulses[idx])
            log_mismatch("msg_tx_ctrl pulses", t_pulses[idx], pulse_cnt - start_pulses);
        if (init_cnt != 4) begin
            err_cnt++;
            $display("init sequence incomplete in test %0d, %0d bytes seen", idx, init_cnt);
        end
    endtask

    initial begin
        bit loaded;
        en          = 1'b1;
        key_down    = 1'b0;
        key_row     = 2'd0;
        key_col     = 2'd0;
        row2        = {MSG_LEN{CHAR_SPACE}};
        ddram_addr  = '0;
        init_cnt    = 0;
        addr_cnt    = 0;
        pulse_cnt   = 0;
        err_cnt     = 0;
        check_cnt   = 0;
        cycles      = 0;
        cycle_limit = 0;
        load_tests(loaded);
        if (loaded) begin
            foreach (t_key[i])
                cycle_limit += (2 * t_hold[i] + 2 * PASS_CYCLES + LCD_CLR_WAIT) * 2;
            @(posedge arst_n);
            foreach (t_key[i]) run_test(i);
        end else begin
            err_cnt++;
            $display("test file missing, malformed or empty");
        end
        $display("checks: %0d errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
/*
 * Testbench clock and reset source
 * 20 ns clock, reset held low for the first 10 cycles
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // Released on a falling edge
    end

endmodule

//--- design/team_11.sv
/*
 * Chip top level for the keypad LCD terminal
 * Stage reset from arst_n and en, GPIO pin map, output enables
 */
`timescale 1ns/1ps

module team_11 (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        en,        // Chip enable, low holds everything in reset
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb   // Active low
);
    import kp_lcd_pkg::*;

    logic                 stage_rst_n;
    logic                 key_valid;
    key_code_e            key_code;
    logic [8*MSG_LEN-1:0] msg_line;
    logic                 msg_changed;

    assign stage_rst_n = arst_n & en;

    // Unused pins and keypad row inputs read back as zero
    assign gpio_out[33:30] = '0;
    assign gpio_out[13:0]  = '0;

    // Rows in, columns and LCD bus out
    assign gpio_oeb = {4'hF, 16'h0000, 14'h3FFF};

    keypad_scanner i_keypad_scanner (
        .clk       (clk),
        .arst_n    (stage_rst_n),
        .readrow   (gpio_in[33:30]),
        .scancol   (gpio_out[29:26]),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    message_builder i_message_builder (
        .clk         (clk),
        .arst_n      (stage_rst_n),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .msg_line    (msg_line),
        .msg_tx_ctrl (gpio_out[25]),
        .msg_changed (msg_changed)
    );

    lcd1602 i_lcd1602 (
        .clk         (clk),
        .arst_n      (stage_rst_n),
        .msg_line    (msg_line),
        .msg_changed (msg_changed),
        .lcd_en      (gpio_out[24]),
        .lcd_rw      (gpio_out[23]),
        .lcd_rs      (gpio_out[22]),
        .lcd_data    (gpio_out[21:14])
    );

endmodule

//--- design/lcd1602.sv
/*
 * HD44780 style LCD1602 driver, 8-bit write-only bus
 * Power-up delay and init list, then endless row-2 refresh
 * Shared enable pulse and wait timer, per-pass line snapshot
 */
`timescale 1ns/1ps

module lcd1602 (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [8*kp_lcd_pkg::MSG_LEN-1:0]  msg_line,
    input  logic                              msg_changed,  // Ends inter-pass wait
    output logic                              lcd_en,
    output logic                              lcd_rw,
    output logic                              lcd_rs,       // 0 command, 1 data
    output logic [7:0]                        lcd_data
);
    import kp_lcd_pkg::*;

    lcd_state_e                      state;
    lcd_state_e                      next_q;     // Where to go after the wait
    logic [$clog2(LCD_CLR_WAIT)-1:0] timer;
    logic                            long_wait;  // Byte was the clear command
    logic [1:0]                      init_idx;
    logic [$clog2(MSG_LEN)-1:0]      char_idx;
    logic [0:MSG_LEN-1][7:0]         snap_q;     // Line held for one pass
    logic                            wait_done;
    logic                            pass_end;

    assign lcd_rw    = 1'b0;  // No busy-flag reads
    assign wait_done = long_wait ? int'(timer) == LCD_CLR_WAIT - 1
                                 : int'(timer) == LCD_CMD_WAIT - 1;
    assign pass_end  = lcd_rs && next_q == LCD_SET_ADDR;  // Last char just sent

    // Snapshot at start of pass
    always_ff @(posedge clk) begin
        if (state == LCD_SET_ADDR)
            snap_q <= msg_line;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= LCD_POWERUP;
            next_q    <= LCD_INIT;
            timer     <= '0;
            long_wait <= 1'b0;
            init_idx  <= 2'd0;
            char_idx  <= '0;
            lcd_en    <= 1'b0;
            lcd_rs    <= 1'b0;
            lcd_data  <= 8'h00;
        end else begin
            case (state)
                LCD_POWERUP: begin
                    timer <= timer + 1'b1;
                    if (int'(timer) == LCD_CLR_WAIT - 1) begin
                        timer <= '0;
                        state <= LCD_INIT;
                    end
                end
                LCD_INIT: begin
                    lcd_rs    <= 1'b0;
                    lcd_data  <= LCD_INIT_BYTES[init_idx];
                    long_wait <= init_idx == 2'd3;  // Clear is last
                    next_q    <= (init_idx == 2'd3) ? LCD_SET_ADDR : LCD_INIT;
                    init_idx  <= init_idx + 2'd1;
                    state     <= LCD_PULSE;
                end
                LCD_SET_ADDR: begin
                    lcd_rs    <= 1'b0;
                    lcd_data  <= LCD_ROW2_ADDR;
                    long_wait <= 1'b0;
                    char_idx  <= '0;
                    next_q    <= LCD_WRITE_CHAR;
                    state     <= LCD_PULSE;
                end
                LCD_WRITE_CHAR: begin
                    lcd_rs    <= 1'b1;
                    lcd_data  <= snap_q[char_idx];
                    long_wait <= 1'b0;
                    next_q    <= (int'(char_idx) == MSG_LEN - 1) ? LCD_SET_ADDR
                                                                 : LCD_WRITE_CHAR;
                    char_idx  <= char_idx + 1'b1;
                    state     <= LCD_PULSE;
                end
                // Data already stable one cycle before enable rises
                LCD_PULSE: begin
                    if (int'(timer) == LCD_EN_CYCLES) begin
                        lcd_en <= 1'b0;
                        timer  <= '0;
                        state  <= LCD_WAIT;
                    end else begin
                        lcd_en <= 1'b1;
                        timer  <= timer + 1'b1;
                    end
                end
                LCD_WAIT: begin
                    timer <= timer + 1'b1;
                    if (wait_done || (msg_changed && pass_end)) begin
                        timer <= '0;
                        state <= next_q;
                    end
                end
                default: state <= LCD_POWERUP;
            endcase
        end
    end

endmodule

//--- design/message_builder.sv
/*
 * Message line builder
 * Key to ASCII map, 16 character line with append, backspace, clear
 * One-cycle change strobe to the pin and the LCD driver
 */
`timescale 1ns/1ps

module message_builder (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              key_valid,
    input  kp_lcd_pkg::key_code_e             key_code,
    output logic [8*kp_lcd_pkg::MSG_LEN-1:0]  msg_line,    // Char 0 in top byte
    output logic                              msg_tx_ctrl,
    output logic                              msg_changed
);
    import kp_lcd_pkg::*;

    logic [0:MSG_LEN-1][7:0]       line_q;    // Index 0 is leftmost
    logic [$clog2(MSG_LEN+1)-1:0]  len_q;     // Characters typed
    logic [$clog2(MSG_LEN)-1:0]    wr_idx;    // Next free slot
    logic [$clog2(MSG_LEN)-1:0]    last_idx;  // Last typed slot
    logic                          changed_q;
    logic [7:0]                    key_char;

    assign msg_line    = line_q;
    assign msg_tx_ctrl = changed_q;
    assign msg_changed = changed_q;  // Same pulse, second consumer
    assign wr_idx      = len_q[$clog2(MSG_LEN)-1:0];
    assign last_idx    = wr_idx - 1'b1;

    // Printable key to ASCII
    always_comb begin
        case (key_code)
            KEY_0:   key_char = "0";
            KEY_1:   key_char = "1";
            KEY_2:   key_char = "2";
            KEY_3:   key_char = "3";
            KEY_4:   key_char = "4";
            KEY_5:   key_char = "5";
            KEY_6:   key_char = "6";
            KEY_7:   key_char = "7";
            KEY_8:   key_char = "8";
            KEY_9:   key_char = "9";
            KEY_A:   key_char = "A";
            KEY_B:   key_char = "B";
            KEY_C:   key_char = "C";
            KEY_D:   key_char = "D";
            default: key_char = CHAR_SPACE;  // Star and hash edit instead
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_q    <= {MSG_LEN{CHAR_SPACE}};
            len_q     <= '0;
            changed_q <= 1'b0;
        end else begin
            changed_q <= 1'b0;
            if (key_valid) begin
                if (key_code == KEY_HASH) begin
                    if (len_q != '0) begin  // Clearing blank line is no change
                        line_q    <= {MSG_LEN{CHAR_SPACE}};
                        len_q     <= '0;
                        changed_q <= 1'b1;
                    end
                end else if (key_code == KEY_STAR) begin
                    if (len_q != '0) begin  // Backspace
                        line_q[last_idx] <= CHAR_SPACE;
                        len_q            <= len_q - 1'b1;
                        changed_q        <= 1'b1;
                    end
                end else if (int'(len_q) < MSG_LEN) begin
                    line_q[wr_idx] <= key_char;
                    len_q          <= len_q + 1'b1;
                    changed_q      <= 1'b1;
                end
            end
        end
    end

endmodule

//--- design/keypad_scanner.sv
/*
 * 4x4 keypad matrix scanner
 * One-hot column drive, per-scan single key detection,
 * press and release debounce, one key_valid pulse per press
 */
`timescale 1ns/1ps

module keypad_scanner (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [3:0]            readrow,   // Active high rows
    output logic [3:0]            scancol,   // One-hot active high
    output logic                  key_valid,
    output kp_lcd_pkg::key_code_e key_code
);
    import kp_lcd_pkg::*;

    scan_state_e                           state;
    logic [$clog2(SCAN_CYCLES)-1:0]        cyc_cnt;
    logic [1:0]                            col_idx;
    logic [1:0]                            row_hits;   // 0, 1, 2 means many
    logic [1:0]                            row_idx;
    logic [1:0]                            scan_hits;  // Hits so far this scan
    logic [1:0]                            sum_hits;
    key_code_e                             scan_key;
    key_code_e                             cur_key;
    key_code_e                             cand;       // Key being debounced
    logic [$clog2(DEBOUNCE_SCANS+1)-1:0]   deb_cnt;
    logic                                  col_end;
    logic                                  scan_done;
    logic                                  scan_single;

    assign scancol     = 4'b0001 << col_idx;
    assign col_end     = int'(cyc_cnt) == SCAN_CYCLES - 1;  // Row sample point
    assign scan_done   = col_end && col_idx == 2'd3;
    assign scan_single = sum_hits == 2'd1;  // Multiple keys count as empty
    assign key_code    = cand;

    // Row decode for the driven column
    always_comb begin
        row_hits = 2'd0;
        row_idx  = 2'd0;
        for (int r = 0; r < 4; r++) begin
            if (readrow[r]) begin
                row_hits = (row_hits == 2'd0) ? 2'd1 : 2'd2;
                row_idx  = 2'(r);
            end
        end
    end

    // Scan totals including the current column
    always_comb begin
        logic [1:0] base;
        base = (col_idx == 2'd0) ? 2'd0 : scan_hits;  // Column 0 starts fresh
        if (base == 2'd0)
            sum_hits = row_hits;
        else if (row_hits == 2'd0)
            sum_hits = base;
        else
            sum_hits = 2'd2;
        cur_key = (row_hits == 2'd1) ? key_code_e'({row_idx, col_idx}) : scan_key;
    end

    // Column rotation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc_cnt   <= '0;
            col_idx   <= 2'd0;
            scan_hits <= 2'd0;
        end else begin
            cyc_cnt <= col_end ? '0 : cyc_cnt + 1'b1;
            if (col_end) begin
                col_idx   <= col_idx + 2'd1;  // Wraps back to column 0
                scan_hits <= sum_hits;
            end
        end
    end

    // Key payload
    always_ff @(posedge clk) begin
        if (col_end)
            scan_key <= cur_key;
        if (scan_done && scan_single && (state == SCAN_IDLE || state == SCAN_DEBOUNCE))
            cand <= cur_key;
    end

    // Press and release debounce, evaluated once per full scan
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SCAN_IDLE;
            deb_cnt   <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (scan_done) begin
                case (state)
                    SCAN_IDLE: begin
                        if (scan_single) begin
                            state   <= SCAN_DEBOUNCE;
                            deb_cnt <= 1;
                        end
                    end
                    SCAN_DEBOUNCE: begin
                        if (!scan_single) begin
                            state <= SCAN_IDLE;
                        end else if (cur_key != cand) begin
                            deb_cnt <= 1;  // Other key restarts count
                        end else if (int'(deb_cnt) == DEBOUNCE_SCANS - 1) begin
                            state     <= SCAN_HELD;
                            key_valid <= 1'b1;
                        end else begin
                            deb_cnt <= deb_cnt + 1'b1;
                        end
                    end
                    SCAN_HELD: begin
                        if (!scan_single) begin
                            state   <= SCAN_RELEASE;
                            deb_cnt <= 1;
                        end
                    end
                    SCAN_RELEASE: begin
                        if (scan_single)
                            state <= SCAN_HELD;  // Bounce, still pressed
                        else if (int'(deb_cnt) == DEBOUNCE_SCANS - 1)
                            state <= SCAN_IDLE;
                        else
                            deb_cnt <= deb_cnt + 1'b1;
                    end
                    default: state <= SCAN_IDLE;
                endcase
            end
        end
    end

endmodule

//--- design/kp_lcd_pkg.sv
/*
 * Shared definitions for the keypad LCD terminal
 * Keypad scan and LCD bus timing, line length
 * Key code and FSM state enums, ASCII space, LCD command bytes
 */
package kp_lcd_pkg;

    // Keypad scan timing
    localparam int SCAN_CYCLES    = 16;  // Cycles each column stays driven
    localparam int DEBOUNCE_SCANS = 3;   // Matching or empty scans needed

    localparam int MSG_LEN = 16;  // Characters on the line

    // LCD bus timing in clock cycles
    localparam int LCD_EN_CYCLES = 8;    // Enable high time
    localparam int LCD_CMD_WAIT  = 40;   // After an ordinary byte
    localparam int LCD_CLR_WAIT  = 400;  // Clear command and power-up

    // Matrix position as row * 4 + col
    typedef enum logic [3:0] {
        KEY_1    = 4'd0,  KEY_2 = 4'd1,  KEY_3    = 4'd2,  KEY_A = 4'd3,
        KEY_4    = 4'd4,  KEY_5 = 4'd5,  KEY_6    = 4'd6,  KEY_B = 4'd7,
        KEY_7    = 4'd8,  KEY_8 = 4'd9,  KEY_9    = 4'd10, KEY_C = 4'd11,
        KEY_STAR = 4'd12, KEY_0 = 4'd13, KEY_HASH = 4'd14, KEY_D = 4'd15
    } key_code_e;

    typedef enum logic [1:0] {
        SCAN_IDLE, SCAN_DEBOUNCE, SCAN_HELD, SCAN_RELEASE
    } scan_state_e;

    typedef enum logic [2:0] {
        LCD_POWERUP, LCD_INIT, LCD_SET_ADDR, LCD_WRITE_CHAR, LCD_PULSE, LCD_WAIT
    } lcd_state_e;

    localparam logic [7:0] CHAR_SPACE = 8'h20;

    // Sent once after power-up, in index order
    localparam logic [7:0] LCD_INIT_BYTES [4] = '{
        8'h38,  // Function set 8-bit two lines
        8'h0C,  // Display on, no cursor
        8'h06,  // Entry mode increment
        8'h01   // Clear display
    };

    localparam logic [7:0] LCD_ROW2_ADDR = 8'hC0;  // DDRAM address 40h

endpackage
